// ==== flist.f ====
mips_pkg.sv
regfile.sv
datapath.sv
mycpu.sv
sram_wb_bridge.sv
mycpu_top.sv
tb_clock.sv
tb_top.sv

// ==== Makefile ====
.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -j 0 --top-module tb_top -f flist.f -o Vtb_top

run: compile
	./obj_dir/Vtb_top | tee sim.log
	grep -q "Simulation finished: PASS" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== tb_top.sv ====
`timescale 1ns/1ps

module tb_top import mips_pkg::*; ();
    localparam int    NUM_TESTS = 7;
    localparam word_t BASE      = 32'hbfc0_0000;  // kseg1 boot vector

    // encodings from the mips32 isa
    localparam logic [5:0] OPC_J     = 6'h02;
    localparam logic [5:0] OPC_BEQ   = 6'h04;
    localparam logic [5:0] OPC_BNE   = 6'h05;
    localparam logic [5:0] OPC_ADDIU = 6'h09;
    localparam logic [5:0] OPC_ORI   = 6'h0d;
    localparam logic [5:0] OPC_LUI   = 6'h0f;
    localparam logic [5:0] OPC_LW    = 6'h23;
    localparam logic [5:0] OPC_SW    = 6'h2b;
    localparam logic [5:0] FN_ADDU_C = 6'h21;
    localparam logic [5:0] FN_SUBU_C = 6'h23;
    localparam logic [5:0] FN_AND_C  = 6'h24;
    localparam logic [5:0] FN_OR_C   = 6'h25;
    localparam logic [5:0] FN_SLT_C  = 6'h2a;

    logic       clk;
    logic       por_reset;
    logic       soft_reset = 1'b0;
    logic       reset;
    logic       wb_cyc;
    logic       wb_stb;
    logic       wb_we;
    word_t      wb_adr;
    word_t      wb_wdata;
    logic [3:0] wb_sel;
    word_t      wb_rdata = '0;
    logic       wb_ack = 1'b0;
    word_t      debug_wb_pc;
    rwen_t      debug_wb_rf_wen;
    creg_addr_t debug_wb_rf_wnum;
    word_t      debug_wb_rf_wdata;

    word_t image   [0:1023];  // loaded into mem while in reset
    word_t mem     [0:1023];
    word_t mem_ref [0:1023];

    // memory model state
    logic       rand_delay = 1'b0;
    integer     seed = 32'he1b7_f8c0;
    logic       busy;
    int         wait_left;
    logic       first_seen;
    word_t      first_adr;
    int         wr_count;
    word_t      last_wr_adr;
    word_t      last_wr_data;
    logic [3:0] last_wr_sel;

    word_t      prog [$];
    word_t      exp_pc [$];
    creg_addr_t exp_num [$];
    word_t      exp_data [$];
    word_t      trace_pc [$];
    creg_addr_t trace_num [$];
    word_t      trace_data [$];
    rwen_t      trace_wen [$];
    int         r0_writes;

    int check_count = 0;
    int err_count   = 0;

    assign reset = por_reset | soft_reset;

    tb_clock u_clock (
        .clk   (clk),
        .reset (por_reset)
    );

    mycpu_top UUT (
        .clk               (clk),
        .reset             (reset),
        .wb_cyc            (wb_cyc),
        .wb_stb            (wb_stb),
        .wb_we             (wb_we),
        .wb_adr            (wb_adr),
        .wb_wdata          (wb_wdata),
        .wb_sel            (wb_sel),
        .wb_rdata          (wb_rdata),
        .wb_ack            (wb_ack),
        .debug_wb_pc       (debug_wb_pc),
        .debug_wb_rf_wen   (debug_wb_rf_wen),
        .debug_wb_rf_wnum  (debug_wb_rf_wnum),
        .debug_wb_rf_wdata (debug_wb_rf_wdata)
    );

    // wishbone slave with 0..3 wait cycles before ack
    always @(posedge clk) begin
        if (reset) begin
            wb_ack    <= 1'b0;
            busy       = 1'b0;
            first_seen = 1'b0;
            wr_count   = 0;
            for (int i = 0; i < 1024; i++) begin
                mem[i] = image[i];
            end
        end else if (wb_cyc && wb_stb && !wb_ack) begin
            if (!first_seen) begin
                first_seen = 1'b1;
                first_adr  = wb_adr;
            end
            if (!busy) begin
                busy      = 1'b1;
                wait_left = rand_delay ? ($random(seed) & 3) : 0;
            end
            if (wait_left == 0) begin
                busy      = 1'b0;
                wb_ack   <= 1'b1;
                wb_rdata <= mem[wb_adr[11:2]];
                if (wb_we) begin
                    mem[wb_adr[11:2]] = wb_wdata;
                    wr_count++;
                    last_wr_adr  = wb_adr;
                    last_wr_data = wb_wdata;
                    last_wr_sel  = wb_sel;
                end
            end else begin
                wait_left--;
            end
        end else begin
            wb_ack <= 1'b0;  // stb drops the cycle after ack
        end
    end

    // writeback trace sampled mid-cycle
    always @(negedge clk) begin
        if (reset) begin
            trace_pc.delete();
            trace_num.delete();
            trace_data.delete();
            trace_wen.delete();
            r0_writes = 0;
        end else if (debug_wb_rf_wen != 4'h0) begin
            trace_pc.push_back(debug_wb_pc);
            trace_num.push_back(debug_wb_rf_wnum);
            trace_data.push_back(debug_wb_rf_wdata);
            trace_wen.push_back(debug_wb_rf_wen);
            if (debug_wb_rf_wnum == 5'd0) begin
                r0_writes++;
            end
        end
    end

    initial begin
        #(NUM_TESTS * 2000 * 100);
        $display("timeout: the tests did not finish within %0d cycles", NUM_TESTS * 2000);
        $display("Simulation finished: FAIL");
        $finish;
    end

    task automatic check_value(input string name, input word_t got, input word_t expected);
        check_count++;
        if (got !== expected) begin
            err_count++;
            $display("mismatch at %0d ns: %s got %h expected %h", $time, name, got, expected);
        end
    endtask

    function automatic word_t enc_r(input creg_addr_t rs, input creg_addr_t rt,
                                    input creg_addr_t rd, input logic [5:0] fn);
        return {6'h00, rs, rt, rd, 5'h00, fn};
    endfunction

    function automatic word_t enc_i(input logic [5:0] op, input creg_addr_t rs,
                                    input creg_addr_t rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic word_t enc_j(input word_t target);
        return {OPC_J, target[27:2]};
    endfunction

    function automatic word_t pc_of(input int idx);
        return BASE + word_t'(idx) * 32'd4;
    endfunction

    // unused words hold a pattern of their own address
    function automatic word_t fill_word(input int idx);
        return {idx[9:0], 2'b00, 8'h5a, ~idx[9:0], 2'b11};
    endfunction

    task automatic new_program();
        prog.delete();
        exp_pc.delete();
        exp_num.delete();
        exp_data.delete();
    endtask

    task automatic emit(input word_t instr);
        prog.push_back(instr);
    endtask

    // expected writeback of the last emitted instruction
    task automatic expect_wb(input creg_addr_t num, input word_t data);
        exp_pc.push_back(pc_of(prog.size() - 1));
        exp_num.push_back(num);
        exp_data.push_back(data);
    endtask

    task automatic halt_here();
        emit(enc_j(pc_of(prog.size())));  // jump to itself
    endtask

    task automatic compare_trace(input string name);
        int n;
        n = (trace_pc.size() < exp_pc.size()) ? trace_pc.size() : exp_pc.size();
        check_value({name, " writeback count"}, trace_pc.size(), exp_pc.size());
        for (int i = 0; i < n; i++) begin
            check_value($sformatf("%s debug_wb_pc[%0d]", name, i), trace_pc[i], exp_pc[i]);
            check_value($sformatf("%s debug_wb_rf_wnum[%0d]", name, i),
                        {27'h0, trace_num[i]}, {27'h0, exp_num[i]});
            check_value($sformatf("%s debug_wb_rf_wdata[%0d]", name, i),
                        trace_data[i], exp_data[i]);
            check_value($sformatf("%s debug_wb_rf_wen[%0d]", name, i),
                        {28'h0, trace_wen[i]}, 32'hf);
        end
    endtask

    task automatic run_program(input string name, input bit rand_on);
        int n;
        @(posedge clk);
        soft_reset <= 1'b1;
        @(posedge clk);
        for (int i = 0; i < 1024; i++) begin
            image[i] = (i < prog.size()) ? prog[i] : fill_word(i);
        end
        rand_delay = rand_on;
        repeat (16) @(posedge clk);
        soft_reset <= 1'b0;
        n = 0;
        while (trace_pc.size() < exp_pc.size() && n < 1500) begin
            @(negedge clk);
            n++;
        end
        if (trace_pc.size() < exp_pc.size()) begin
            err_count++;
            $display("%s: core stalled, only %0d of %0d writebacks seen",
                     name, trace_pc.size(), exp_pc.size());
        end
        repeat (40) @(negedge clk);  // catch stray writebacks
        compare_trace(name);
    endtask

    task automatic reset_test();
        int n;
        for (int i = 0; i < 1024; i++) begin
            image[i] = fill_word(i);
        end
        image[0] = enc_j(BASE);
        repeat (4) begin
            @(negedge clk);
            check_value("wb_cyc in reset", {31'h0, wb_cyc}, 32'h0);
            check_value("wb_stb in reset", {31'h0, wb_stb}, 32'h0);
            check_value("debug_wb_rf_wen in reset", {28'h0, debug_wb_rf_wen}, 32'h0);
        end
        while (reset) @(negedge clk);
        check_value("wb_cyc after reset", {31'h0, wb_cyc}, 32'h0);
        check_value("wb_stb after reset", {31'h0, wb_stb}, 32'h0);
        n = 0;
        while (!first_seen && n < 100) begin
            @(negedge clk);
            n++;
        end
        if (!first_seen) begin
            err_count++;
            $display("reset: no wishbone cycle started after reset");
        end else begin
            check_value("first wb_adr", first_adr, 32'h1fc0_0000);
        end
    endtask

    task automatic alu_test(input bit rand_on);
        word_t r1;
        word_t r2;
        new_program();
        r1 = 32'h1234_0000;
        emit(enc_i(OPC_LUI, 5'd0, 5'd1, 16'h1234));
        expect_wb(5'd1, r1);
        r1 = r1 | 32'h0000_a5a5;  // zero-extended
        emit(enc_i(OPC_ORI, 5'd1, 5'd1, 16'ha5a5));
        expect_wb(5'd1, r1);
        r2 = 32'hffff_ff00;  // -256 sign-extended
        emit(enc_i(OPC_ADDIU, 5'd0, 5'd2, 16'hff00));
        expect_wb(5'd2, r2);
        emit(enc_r(5'd1, 5'd2, 5'd3, FN_ADDU_C));
        expect_wb(5'd3, r1 + r2);
        emit(enc_r(5'd1, 5'd2, 5'd4, FN_SUBU_C));
        expect_wb(5'd4, r1 - r2);
        emit(enc_r(5'd1, 5'd2, 5'd5, FN_AND_C));
        expect_wb(5'd5, r1 & r2);
        emit(enc_r(5'd1, 5'd2, 5'd6, FN_OR_C));
        expect_wb(5'd6, r1 | r2);
        emit(enc_r(5'd2, 5'd1, 5'd7, FN_SLT_C));
        expect_wb(5'd7, 32'd1);  // negative < positive
        emit(enc_r(5'd1, 5'd2, 5'd8, FN_SLT_C));
        expect_wb(5'd8, 32'd0);
        halt_here();
        run_program(rand_on ? "alu, random ack" : "alu", rand_on);
    endtask

    task automatic load_store_test(input bit rand_on);
        word_t r2;
        word_t r4;
        new_program();
        emit(enc_i(OPC_LUI, 5'd0, 5'd1, 16'h8000));
        expect_wb(5'd1, 32'h8000_0000);
        emit(enc_i(OPC_ORI, 5'd1, 5'd1, 16'h0100));
        expect_wb(5'd1, 32'h8000_0100);  // kseg0 data pointer
        emit(enc_i(OPC_LUI, 5'd0, 5'd2, 16'hcafe));
        expect_wb(5'd2, 32'hcafe_0000);
        r2 = 32'hcafe_f00d;
        emit(enc_i(OPC_ORI, 5'd2, 5'd2, 16'hf00d));
        expect_wb(5'd2, r2);
        emit(enc_i(OPC_SW, 5'd1, 5'd2, 16'h0004));
        emit(enc_i(OPC_LW, 5'd1, 5'd3, 16'h0004));
        expect_wb(5'd3, r2);
        r4 = fill_word(64);  // untouched word at 0x100
        emit(enc_i(OPC_LW, 5'd1, 5'd4, 16'h0000));
        expect_wb(5'd4, r4);
        emit(enc_r(5'd3, 5'd4, 5'd5, FN_ADDU_C));
        expect_wb(5'd5, r2 + r4);
        halt_here();
        run_program(rand_on ? "load/store, random ack" : "load/store", rand_on);
        check_value("wishbone write count", wr_count, 1);
        check_value("wb_adr of write", last_wr_adr, 32'h0000_0104);
        check_value("wb_wdata of write", last_wr_data, r2);
        check_value("wb_sel of write", {28'h0, last_wr_sel}, 32'hf);
        check_value("memory word 0x104", mem[65], r2);
        for (int i = 0; i < 1024; i++) begin
            if (!rand_on) begin
                mem_ref[i] = mem[i];
            end else begin
                check_value($sformatf("memory word %0d", i), mem[i], mem_ref[i]);
            end
        end
    endtask

    task automatic branch_test();
        new_program();
        emit(enc_i(OPC_ADDIU, 5'd0, 5'd1, 16'h0005));
        expect_wb(5'd1, 32'd5);
        emit(enc_i(OPC_ADDIU, 5'd0, 5'd2, 16'h0005));
        expect_wb(5'd2, 32'd5);
        emit(enc_i(OPC_BEQ, 5'd1, 5'd2, 16'h0002));  // taken to 5
        emit(enc_i(OPC_ADDIU, 5'd0, 5'd3, 16'h0033));
        emit(enc_i(OPC_ADDIU, 5'd0, 5'd3, 16'h0044));
        emit(enc_i(OPC_ADDIU, 5'd0, 5'd4, 16'h0001));
        expect_wb(5'd4, 32'd1);
        emit(enc_i(OPC_BEQ, 5'd1, 5'd4, 16'h0001));  // not taken
        emit(enc_i(OPC_ADDIU, 5'd0, 5'd5, 16'h0002));
        expect_wb(5'd5, 32'd2);
        emit(enc_i(OPC_BNE, 5'd1, 5'd4, 16'h0002));  // taken to 11
        emit(enc_i(OPC_ADDIU, 5'd0, 5'd6, 16'h0009));
        emit(enc_i(OPC_ADDIU, 5'd0, 5'd6, 16'h000a));
        emit(enc_j(pc_of(14)));
        emit(enc_i(OPC_ADDIU, 5'd0, 5'd7, 16'h0007));
        emit(enc_i(OPC_ADDIU, 5'd0, 5'd7, 16'h0007));
        emit(enc_i(OPC_ADDIU, 5'd0, 5'd8, 16'h0008));
        expect_wb(5'd8, 32'd8);
        emit(enc_i(OPC_BNE, 5'd1, 5'd2, 16'h0001));  // falls through on equal
        emit(enc_i(OPC_ADDIU, 5'd0, 5'd9, 16'h0099));
        expect_wb(5'd9, 32'h99);
        emit(enc_i(OPC_BEQ, 5'd0, 5'd0, 16'hffff));  // offset -1 loops on itself
        run_program("branch", 1'b0);
    endtask

    task automatic reg_zero_test();
        new_program();
        emit(enc_i(OPC_ADDIU, 5'd0, 5'd1, 16'h0077));
        expect_wb(5'd1, 32'h77);
        emit(enc_i(OPC_ADDIU, 5'd1, 5'd0, 16'h0055));  // r0 stays zero
        emit(enc_r(5'd0, 5'd1, 5'd2, FN_ADDU_C));
        expect_wb(5'd2, 32'h77);
        emit(enc_r(5'd0, 5'd0, 5'd3, FN_OR_C));
        expect_wb(5'd3, 32'h0);
        halt_here();
        run_program("register 0", 1'b0);
        check_value("debug_wb_rf_wen writes to r0", r0_writes, 0);
    endtask

    initial begin
        reset_test();
        alu_test(1'b0);
        load_store_test(1'b0);
        branch_test();
        reg_zero_test();
        alu_test(1'b1);  // wait-state reruns
        load_store_test(1'b1);
        $display("checks %0d, errors %0d", check_count, err_count);
        if (err_count == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

// ==== tb_clock.sv ====
`timescale 1ns/1ps

module tb_clock #(
    parameter int PERIOD       = 100,
    parameter int RESET_CYCLES = 16
) (
    output logic clk,
    output logic reset
);
    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    // power-on reset, released on a rising edge
    initial begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;
    end

endmodule

// ==== mycpu_top.sv ====
`timescale 1ns/1ps

module mycpu_top import mips_pkg::*; #(
    parameter word_t RESET_PC = mips_pkg::RESET_PC
) (
    input  logic       clk,
    input  logic       reset,

    output logic       wb_cyc,
    output logic       wb_stb,
    output logic       wb_we,
    output word_t      wb_adr,
    output word_t      wb_wdata,
    output logic [3:0] wb_sel,
    input  word_t      wb_rdata,
    input  logic       wb_ack,

    output word_t      debug_wb_pc,
    output rwen_t      debug_wb_rf_wen,
    output creg_addr_t debug_wb_rf_wnum,
    output word_t      debug_wb_rf_wdata
);
    logic  inst_req;
    logic  data_req;
    logic  data_wr;
    word_t inst_addr;
    word_t data_addr;
    word_t data_wdata;
    word_t inst_rdata;
    word_t data_rdata;
    logic  inst_addr_ok;
    logic  data_addr_ok;
    logic  inst_data_ok;
    logic  data_data_ok;

    mycpu #(
        .RESET_PC (RESET_PC)
    ) u_mycpu (
        .clk, .reset,
        .inst_req, .inst_addr, .inst_rdata, .inst_addr_ok, .inst_data_ok,
        .data_req, .data_wr, .data_addr, .data_wdata, .data_rdata,
        .data_addr_ok, .data_data_ok,
        .debug_wb_pc, .debug_wb_rf_wen, .debug_wb_rf_wnum, .debug_wb_rf_wdata
    );

    sram_wb_bridge u_bridge (
        .clk, .reset,
        .inst_req, .inst_addr, .inst_rdata, .inst_addr_ok, .inst_data_ok,
        .data_req, .data_wr, .data_addr, .data_wdata, .data_rdata,
        .data_addr_ok, .data_data_ok,
        .wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_wdata, .wb_sel, .wb_rdata, .wb_ack
    );

endmodule

// ==== sram_wb_bridge.sv ====
`timescale 1ns/1ps

module sram_wb_bridge import mips_pkg::*; (
    input  logic  clk,
    input  logic  reset,

    input  logic  inst_req,
    input  word_t inst_addr,
    output word_t inst_rdata,
    output logic  inst_addr_ok,
    output logic  inst_data_ok,

    input  logic  data_req,
    input  logic  data_wr,
    input  word_t data_addr,
    input  word_t data_wdata,
    output word_t data_rdata,
    output logic  data_addr_ok,
    output logic  data_data_ok,

    output logic  wb_cyc,
    output logic  wb_stb,
    output logic  wb_we,
    output word_t wb_adr,
    output word_t wb_wdata,
    output logic [3:0] wb_sel,
    input  word_t wb_rdata,
    input  logic  wb_ack
);
    typedef enum logic [1:0] {
        IDLE,
        BUS,
        DONE
    } bus_state_t;

    bus_state_t state;
    logic       owner_d;    // current cycle belongs to the data port
    logic       addr_ok_q;  // high in the first bus cycle
    logic       we_q;
    word_t      adr_q;
    word_t      wdata_q;
    word_t      rdata_q;

    always_ff @(posedge clk) begin
        if (reset) begin
            state     <= IDLE;
            owner_d   <= 1'b0;
            addr_ok_q <= 1'b0;
        end else begin
            addr_ok_q <= 1'b0;
            case (state)
                IDLE: begin
                    if (data_req || inst_req) begin
                        owner_d   <= data_req;  // data wins
                        addr_ok_q <= 1'b1;
                        state     <= BUS;
                    end
                end
                BUS: begin
                    if (wb_ack) begin
                        state <= DONE;
                    end
                end
                DONE:    state <= IDLE;
                default: state <= IDLE;
            endcase
        end
    end

    // request fields sampled while idle, held for the whole bus cycle
    always_ff @(posedge clk) begin
        if (state == IDLE) begin
            adr_q   <= data_req ? data_addr : inst_addr;
            we_q    <= data_req && data_wr;
            wdata_q <= data_wdata;
        end
        if (state == BUS && wb_ack) begin
            rdata_q <= wb_rdata;
        end
    end

    assign wb_cyc   = (state == BUS);
    assign wb_stb   = (state == BUS);
    assign wb_we    = we_q;
    assign wb_adr   = adr_q;
    assign wb_wdata = wdata_q;
    assign wb_sel   = 4'hf;  // word accesses only

    assign inst_addr_ok = addr_ok_q && !owner_d;
    assign data_addr_ok = addr_ok_q && owner_d;
    assign inst_data_ok = (state == DONE) && !owner_d;
    assign data_data_ok = (state == DONE) && owner_d;
    assign inst_rdata   = rdata_q;
    assign data_rdata   = rdata_q;

endmodule

// ==== mycpu.sv ====
`timescale 1ns/1ps

module mycpu import mips_pkg::*; #(
    parameter word_t RESET_PC = mips_pkg::RESET_PC
) (
    input  logic       clk,
    input  logic       reset,

    output logic       inst_req,
    output word_t      inst_addr,
    input  word_t      inst_rdata,
    input  logic       inst_addr_ok,
    input  logic       inst_data_ok,

    output logic       data_req,
    output logic       data_wr,
    output word_t      data_addr,
    output word_t      data_wdata,
    input  word_t      data_rdata,
    input  logic       data_addr_ok,
    input  logic       data_data_ok,

    output word_t      debug_wb_pc,
    output rwen_t      debug_wb_rf_wen,
    output creg_addr_t debug_wb_rf_wnum,
    output word_t      debug_wb_rf_wdata
);
    word_t      pc;
    word_t      mem_addr;
    word_t      mem_wd;
    word_t      rf_wd;
    creg_addr_t rf_waddr;
    logic       fetch_req;
    logic       fetch_done;
    logic       mem_ren;
    logic       mem_wen;
    logic       mem_done;
    logic       rf_wen;
    logic       inst_wait;  // address taken, data pending
    logic       data_wait;

    // kseg0/kseg1 are unmapped, just strip the segment bits
    function automatic word_t seg_map(input word_t va);
        case (va[31:28])
            4'h8, 4'h9, 4'ha, 4'hb: seg_map = {3'b000, va[28:0]};
            default:                seg_map = va;
        endcase
    endfunction

    datapath #(
        .RESET_PC (RESET_PC)
    ) u_datapath (
        .clk        (clk),
        .reset      (reset),
        .pc         (pc),
        .fetch_req  (fetch_req),
        .instr      (inst_rdata),
        .fetch_done (fetch_done),
        .mem_ren    (mem_ren),
        .mem_wen    (mem_wen),
        .mem_addr   (mem_addr),
        .mem_wd     (mem_wd),
        .mem_rd     (data_rdata),
        .mem_done   (mem_done),
        .rf_wen     (rf_wen),
        .rf_waddr   (rf_waddr),
        .rf_wd      (rf_wd),
        .wb_pc      (debug_wb_pc)
    );

    always_ff @(posedge clk) begin
        if (reset) begin
            inst_req  <= 1'b0;
            inst_wait <= 1'b0;
        end else begin
            if (fetch_req) begin
                inst_req <= 1'b1;
            end else if (inst_addr_ok) begin
                inst_req <= 1'b0;
            end
            if (inst_req && inst_addr_ok) begin
                inst_wait <= 1'b1;
            end else if (inst_data_ok) begin
                inst_wait <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            data_req  <= 1'b0;
            data_wr   <= 1'b0;
            data_wait <= 1'b0;
        end else begin
            if (mem_ren || mem_wen) begin
                data_req <= 1'b1;
                data_wr  <= mem_wen;
            end else if (data_addr_ok) begin
                data_req <= 1'b0;
            end
            if (data_req && data_addr_ok) begin
                data_wait <= 1'b1;
            end else if (data_data_ok) begin
                data_wait <= 1'b0;
            end
        end
    end

    assign fetch_done = inst_wait && inst_data_ok;
    assign mem_done   = data_wait && data_data_ok;

    assign inst_addr  = seg_map(pc);
    assign data_addr  = seg_map(mem_addr);
    assign data_wdata = mem_wd;

    assign debug_wb_rf_wen   = {4{rf_wen && (rf_waddr != '0)}};
    assign debug_wb_rf_wnum  = rf_waddr;
    assign debug_wb_rf_wdata = rf_wd;

endmodule

// ==== datapath.sv ====
`timescale 1ns/1ps

module datapath import mips_pkg::*; #(
    parameter word_t RESET_PC = mips_pkg::RESET_PC
) (
    input  logic       clk,
    input  logic       reset,
    output word_t      pc,
    output logic       fetch_req,
    input  word_t      instr,
    input  logic       fetch_done,
    output logic       mem_ren,
    output logic       mem_wen,
    output word_t      mem_addr,
    output word_t      mem_wd,
    input  word_t      mem_rd,
    input  logic       mem_done,
    output logic       rf_wen,
    output creg_addr_t rf_waddr,
    output word_t      rf_wd,
    output word_t      wb_pc
);
    core_state_t state;
    word_t       ir;

    // values held from EXEC to WB
    word_t alu_q;
    word_t store_q;
    word_t load_q;
    word_t npc_q;

    opcode_t    op;
    funct_t     fn;
    creg_addr_t rs;
    creg_addr_t rt;
    creg_addr_t rd;
    word_t      imm_se;
    word_t      imm_ze;
    word_t      rs_val;
    word_t      rt_val;
    word_t      alu_res;
    word_t      pc_plus4;
    word_t      br_target;
    word_t      j_target;
    word_t      npc;
    logic       wr_en;
    logic       is_load;
    logic       is_store;

    assign op     = opcode_t'(ir[31:26]);
    assign fn     = funct_t'(ir[5:0]);
    assign rs     = ir[25:21];
    assign rt     = ir[20:16];
    assign rd     = ir[15:11];
    assign imm_se = {{16{ir[15]}}, ir[15:0]};
    assign imm_ze = {16'h0, ir[15:0]};

    assign is_load  = (op == OP_LW);
    assign is_store = (op == OP_SW);

    regfile u_regfile (
        .clk   (clk),
        .reset (reset),
        .ra1   (rs),
        .ra2   (rt),
        .wen   (rf_wen),
        .wa    (rf_waddr),
        .wd    (rf_wd),
        .rd1   (rs_val),
        .rd2   (rt_val)
    );

    // alu and write decode
    always_comb begin
        alu_res = '0;
        wr_en   = 1'b0;
        case (op)
            OP_RTYPE: begin
                wr_en = 1'b1;
                case (fn)
                    FN_ADDU: alu_res = rs_val + rt_val;
                    FN_SUBU: alu_res = rs_val - rt_val;
                    FN_AND:  alu_res = rs_val & rt_val;
                    FN_OR:   alu_res = rs_val | rt_val;
                    FN_SLT:  alu_res = {31'h0, $signed(rs_val) < $signed(rt_val)};
                    default: wr_en = 1'b0;  // nop and anything unsupported
                endcase
            end
            OP_ADDIU, OP_LW: begin
                alu_res = rs_val + imm_se;
                wr_en   = 1'b1;
            end
            OP_SW:  alu_res = rs_val + imm_se;  // address only
            OP_ORI: begin
                alu_res = rs_val | imm_ze;
                wr_en   = 1'b1;
            end
            OP_LUI: begin
                alu_res = {ir[15:0], 16'h0};
                wr_en   = 1'b1;
            end
            default: ;
        endcase
    end

    assign pc_plus4  = pc + 32'd4;
    assign br_target = pc_plus4 + {imm_se[29:0], 2'b00};
    assign j_target  = {pc[31:28], ir[25:0], 2'b00};

    always_comb begin
        case (op)
            OP_BEQ:  npc = (rs_val == rt_val) ? br_target : pc_plus4;
            OP_BNE:  npc = (rs_val != rt_val) ? br_target : pc_plus4;
            OP_J:    npc = j_target;
            default: npc = pc_plus4;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= FETCH;
            pc    <= RESET_PC;
            ir    <= '0;  // decodes as nop
            wb_pc <= '0;
        end else begin
            case (state)
                FETCH:  state <= WAIT_I;
                WAIT_I: begin
                    if (fetch_done) begin
                        ir    <= instr;
                        state <= EXEC;
                    end
                end
                EXEC: begin
                    wb_pc <= pc;
                    state <= (is_load || is_store) ? MEM : WB;
                end
                MEM:    state <= WAIT_D;
                WAIT_D: begin
                    if (mem_done) begin
                        state <= WB;
                    end
                end
                WB: begin
                    pc    <= npc_q;
                    state <= FETCH;
                end
                default: state <= FETCH;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == EXEC) begin
            alu_q   <= alu_res;
            store_q <= rt_val;
            npc_q   <= npc;
        end
        if (state == WAIT_D && mem_done) begin
            load_q <= mem_rd;
        end
    end

    assign fetch_req = (state == FETCH);
    assign mem_ren   = (state == MEM) && is_load;
    assign mem_wen   = (state == MEM) && is_store;
    assign mem_addr  = alu_q;
    assign mem_wd    = store_q;

    // rd for r-type, rt otherwise
    assign rf_waddr = (op == OP_RTYPE) ? rd : rt;
    assign rf_wen   = (state == WB) && wr_en;
    assign rf_wd    = is_load ? load_q : alu_q;

endmodule

// ==== regfile.sv ====
`timescale 1ns/1ps

module regfile import mips_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  creg_addr_t ra1,
    input  creg_addr_t ra2,
    input  logic       wen,
    input  creg_addr_t wa,
    input  word_t      wd,
    output word_t      rd1,
    output word_t      rd2
);
    word_t regs [31:0];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wen && (wa != '0)) begin
            regs[wa] <= wd;
        end
    end

    // r0 reads as zero
    assign rd1 = (ra1 == '0) ? '0 : regs[ra1];
    assign rd2 = (ra2 == '0) ? '0 : regs[ra2];

endmodule

// ==== mips_pkg.sv ====
package mips_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  creg_addr_t;
    typedef logic [3:0]  rwen_t;       // one bit per byte lane

    // major opcodes
    typedef enum logic [5:0] {
        OP_RTYPE = 6'h00,
        OP_J     = 6'h02,
        OP_BEQ   = 6'h04,
        OP_BNE   = 6'h05,
        OP_ADDIU = 6'h09,
        OP_ORI   = 6'h0d,
        OP_LUI   = 6'h0f,
        OP_LW    = 6'h23,
        OP_SW    = 6'h2b
    } opcode_t;

    // r-type function field
    typedef enum logic [5:0] {
        FN_ADDU = 6'h21,
        FN_SUBU = 6'h23,
        FN_AND  = 6'h24,
        FN_OR   = 6'h25,
        FN_SLT  = 6'h2a
    } funct_t;

    typedef enum logic [2:0] {
        FETCH,
        WAIT_I,
        EXEC,
        MEM,
        WAIT_D,
        WB
    } core_state_t;

    localparam word_t RESET_PC = 32'hbfc0_0000;  // kseg1 boot vector

endpackage
